// ==== logic/nes_mem_pkg.sv ====
// shared definitions for the shared word memory
// address widths and ram depth
// memory word with byte lane and whole word views
// softcore bridge state encoding

package nes_mem_pkg;

    ////////////////////////////////////////
    // widths and depth
    ////////////////////////////////////////

    localparam int CPU_AW      = 22;               // console byte address
    localparam int RV_AW       = 23;               // softcore byte address
    localparam int RAM_WORD_AW = 12;               // 16-bit word address
    localparam int RAM_WORDS   = 1 << RAM_WORD_AW; // 4096 words, 8 KiB

    ////////////////////////////////////////
    // memory word
    ////////////////////////////////////////

    // one 16-bit word of the ram
    // lane[0] is the even byte address, lane[1] the odd one
    typedef union packed {
        logic [15:0]     word;
        logic [1:0][7:0] lane;
    } mem_word_t;

    ////////////////////////////////////////
    // softcore bridge states
    ////////////////////////////////////////

    localparam logic [2:0] RV_IDLE_REQ0  = 3'd0; // idle, may issue first word
    localparam logic [2:0] RV_WAIT0_REQ1 = 3'd1; // wait low word, issue high word
    localparam logic [2:0] RV_DATA0      = 3'd2; // capture low read word
    localparam logic [2:0] RV_WAIT1      = 3'd3; // wait high word
    localparam logic [2:0] RV_DATA1      = 3'd4; // read result complete

endpackage

// ==== logic/word_ram.sv ====
`timescale 1ns/10ps
// single port word ram, 4096 x 16
// per byte lane write enables, registered read

module word_ram (
    input  logic                                clk,
    input  logic [nes_mem_pkg::RAM_WORD_AW-1:0] i_addr,
    input  logic                                i_we,
    input  logic [1:0]                          i_be,
    input  nes_mem_pkg::mem_word_t              i_wdata,
    output nes_mem_pkg::mem_word_t              o_rdata
);

    nes_mem_pkg::mem_word_t mem [nes_mem_pkg::RAM_WORDS];

    ////////////////////////////////////////
    // write, one lane at a time
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_we) begin
            for (int i = 0; i < 2; i++) begin
                if (i_be[i]) begin
                    mem[i_addr].lane[i] <= i_wdata.lane[i];
                end
            end
        end
    end

    // read returns the old word on a same cycle write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_addr];
    end

endmodule

// ==== logic/loader_port.sv ====
`timescale 1ns/10ps
// console side byte port
// merges cpu strobes and rom loader writes into one byte request
// console reset from the edges of loading

module loader_port (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           i_loading,
    input  logic                           i_loader_write,
    input  logic [nes_mem_pkg::CPU_AW-1:0] i_loader_addr,
    input  logic [7:0]                     i_loader_data,
    input  logic [nes_mem_pkg::CPU_AW-1:0] i_cpu_addr,
    input  logic                           i_cpu_read,
    input  logic                           i_cpu_write,
    input  logic [7:0]                     i_cpu_din,
    output logic                           o_port_req,
    output logic                           o_port_we,
    output logic [nes_mem_pkg::CPU_AW-1:0] o_port_addr,
    output logic [7:0]                     o_port_wdata,
    output logic                           o_reset_nes
);

    logic loading_r;
    logic load_rise;
    logic load_fall;
    logic loader_go;
    logic cpu_go;

    assign load_rise = i_loading & ~loading_r;
    assign load_fall = ~i_loading & loading_r;

    // the loader owns the port for the whole load
    assign loader_go = i_loading & i_loader_write;
    assign cpu_go    = ~i_loading & (i_cpu_read | i_cpu_write);

    ////////////////////////////////////////
    // console reset
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            loading_r   <= 1'b0;
            o_reset_nes <= 1'b1;  // console held until first load ends
        end else begin
            loading_r <= i_loading;
            if (load_rise) begin
                o_reset_nes <= 1'b1;
            end else if (load_fall) begin
                o_reset_nes <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // byte request
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_port_req <= 1'b0;
            o_port_we  <= 1'b0;
        end else begin
            o_port_req <= loader_go | cpu_go;  // single cycle pulse
            o_port_we  <= loader_go | (cpu_go & i_cpu_write);
        end
    end

    // address and data of the request
    always_ff @(posedge clk) begin
        if (loader_go) begin
            o_port_addr  <= i_loader_addr;
            o_port_wdata <= i_loader_data;
        end else if (cpu_go) begin
            o_port_addr  <= i_cpu_addr;
            o_port_wdata <= i_cpu_din;
        end
    end

endmodule

// ==== logic/rv_bridge.sv ====
`timescale 1ns/10ps
// softcore bus bridge
// one 32-bit transfer becomes one or two 16-bit word accesses
// word accesses are handed over with a toggle req / ack pair

module rv_bridge (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                i_rv_valid,
    input  logic [nes_mem_pkg::RV_AW-1:0]       i_rv_addr,
    input  logic [31:0]                         i_rv_wdata,
    input  logic [3:0]                          i_rv_wstrb,
    output logic                                o_rv_ready,
    output logic [31:0]                         o_rv_rdata,
    output logic                                o_rv_req,
    input  logic                                i_rv_req_ack,
    output logic [nes_mem_pkg::RAM_WORD_AW-1:0] o_rv_word_addr,
    output logic                                o_rv_we,
    output logic [1:0]                          o_rv_ds,
    output nes_mem_pkg::mem_word_t              o_rv_wdata,
    input  nes_mem_pkg::mem_word_t              i_rv_rdata
);

    logic [2:0]  rv_state;
    logic        rv_valid_r;
    logic        rv_new_req;    // edge seen while still busy
    logic        rv_new_req_t;  // edge in this cycle
    logic        rv_write;
    logic        rv_done;       // current word access finished
    logic        rv_word;       // 0 low word, 1 high word
    logic [15:0] rv_dout0;

    assign rv_new_req_t = i_rv_valid & ~rv_valid_r;
    assign rv_write     = i_rv_wstrb != 4'b0;
    assign rv_done      = o_rv_req == i_rv_req_ack;

    // softcore holds address and data steady while valid
    assign o_rv_word_addr  = {i_rv_addr[nes_mem_pkg::RAM_WORD_AW:2], rv_word};
    assign o_rv_we         = rv_write;
    assign o_rv_wdata.word = rv_word ? i_rv_wdata[31:16] : i_rv_wdata[15:0];
    assign o_rv_rdata      = {i_rv_rdata.word, rv_dout0};

    ////////////////////////////////////////
    // transfer fsm
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rv_state   <= nes_mem_pkg::RV_IDLE_REQ0;
            rv_valid_r <= 1'b0;
            rv_new_req <= 1'b0;
            o_rv_req   <= 1'b0;
            o_rv_ready <= 1'b0;
        end else begin
            rv_valid_r <= i_rv_valid;
            o_rv_ready <= 1'b0;
            if (rv_new_req_t) begin
                rv_new_req <= 1'b1;
            end

            case (rv_state)
                nes_mem_pkg::RV_IDLE_REQ0: begin
                    if (rv_new_req || rv_new_req_t) begin
                        rv_new_req <= 1'b0;
                        o_rv_req   <= ~o_rv_req;
                        if (rv_write && i_rv_wstrb[1:0] == 2'b0) begin
                            rv_word  <= 1'b1;  // high half only
                            o_rv_ds  <= i_rv_wstrb[3:2];
                            rv_state <= nes_mem_pkg::RV_WAIT1;
                        end else begin
                            rv_word  <= 1'b0;
                            o_rv_ds  <= rv_write ? i_rv_wstrb[1:0] : 2'b11;
                            rv_state <= nes_mem_pkg::RV_WAIT0_REQ1;
                        end
                    end
                end

                nes_mem_pkg::RV_WAIT0_REQ1: begin
                    if (rv_done) begin
                        rv_word <= 1'b1;
                        if (rv_write && i_rv_wstrb[3:2] == 2'b0) begin
                            o_rv_ready <= 1'b1;  // low half only, done
                            rv_state   <= nes_mem_pkg::RV_IDLE_REQ0;
                        end else if (rv_write) begin
                            o_rv_req <= ~o_rv_req;
                            o_rv_ds  <= i_rv_wstrb[3:2];
                            rv_state <= nes_mem_pkg::RV_WAIT1;
                        end else begin
                            o_rv_req <= ~o_rv_req;
                            o_rv_ds  <= 2'b11;
                            rv_state <= nes_mem_pkg::RV_DATA0;
                        end
                    end
                end

                nes_mem_pkg::RV_DATA0: begin
                    rv_dout0 <= i_rv_rdata.word;  // arbiter holds it until next ack
                    rv_state <= nes_mem_pkg::RV_WAIT1;
                end

                nes_mem_pkg::RV_WAIT1: begin
                    if (rv_done) begin
                        if (rv_write) begin
                            o_rv_ready <= 1'b1;
                            rv_state   <= nes_mem_pkg::RV_IDLE_REQ0;
                        end else begin
                            rv_state <= nes_mem_pkg::RV_DATA1;
                        end
                    end
                end

                nes_mem_pkg::RV_DATA1: begin
                    o_rv_ready <= 1'b1;  // high word still on i_rv_rdata
                    rv_state   <= nes_mem_pkg::RV_IDLE_REQ0;
                end

                default: begin
                    rv_state <= nes_mem_pkg::RV_IDLE_REQ0;
                end
            endcase
        end
    end

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/10ps
// fixed priority arbiter for the word ram
// byte port first, softcore toggle requests when the port is quiet
// byte read return with hold, softcore word return with ack

module mem_arbiter (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                i_port_req,
    input  logic                                i_port_we,
    input  logic [nes_mem_pkg::CPU_AW-1:0]      i_port_addr,
    input  logic [7:0]                          i_port_wdata,
    output logic [7:0]                          o_port_rdata,
    input  logic                                i_rv_req,
    output logic                                o_rv_req_ack,
    input  logic [nes_mem_pkg::RAM_WORD_AW-1:0] i_rv_word_addr,
    input  logic                                i_rv_we,
    input  logic [1:0]                          i_rv_ds,
    input  nes_mem_pkg::mem_word_t              i_rv_wdata,
    output nes_mem_pkg::mem_word_t              o_rv_rdata,
    output logic [nes_mem_pkg::RAM_WORD_AW-1:0] o_ram_addr,
    output logic                                o_ram_we,
    output logic [1:0]                          o_ram_be,
    output nes_mem_pkg::mem_word_t              o_ram_wdata,
    input  nes_mem_pkg::mem_word_t              i_ram_rdata
);

    logic                   rv_req_q;
    logic                   rv_pend;      // softcore word access waiting
    logic                   rv_inflight;  // softcore word on ram output
    logic                   port_rd_pend; // byte read on ram output
    logic                   port_lane_q;
    logic [7:0]             port_hold;
    logic [7:0]             port_byte;
    logic                   grant_port;
    logic                   grant_rv;
    nes_mem_pkg::mem_word_t port_word;

    // byte port never waits
    assign grant_port = i_port_req;
    assign grant_rv   = rv_pend & ~i_port_req;

    assign port_word.lane = {2{i_port_wdata}};  // byte_en picks the lane
    assign port_byte      = i_ram_rdata.lane[port_lane_q];

    ////////////////////////////////////////
    // ram access
    ////////////////////////////////////////

    always_comb begin
        o_ram_addr  = i_rv_word_addr;
        o_ram_we    = grant_rv & i_rv_we;
        o_ram_be    = i_rv_ds;
        o_ram_wdata = i_rv_wdata;
        if (grant_port) begin
            o_ram_addr  = i_port_addr[nes_mem_pkg::RAM_WORD_AW:1]; // wraps at 8 KiB
            o_ram_we    = i_port_we;
            o_ram_be    = i_port_addr[0] ? 2'b10 : 2'b01;
            o_ram_wdata = port_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rv_req_q     <= 1'b0;
            rv_pend      <= 1'b0;
            rv_inflight  <= 1'b0;
            port_rd_pend <= 1'b0;
            o_rv_req_ack <= 1'b0;
        end else begin
            rv_req_q     <= i_rv_req;
            rv_inflight  <= grant_rv;
            port_rd_pend <= grant_port & ~i_port_we;
            if (i_rv_req != rv_req_q) begin
                rv_pend <= 1'b1;  // toggle means new request
            end else if (grant_rv) begin
                rv_pend <= 1'b0;
            end
            if (rv_inflight) begin
                o_rv_req_ack <= ~o_rv_req_ack;
            end
        end
    end

    ////////////////////////////////////////
    // read return
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (grant_port) begin
            port_lane_q <= i_port_addr[0];
        end
        if (port_rd_pend) begin
            port_hold <= port_byte;
        end
        if (rv_inflight) begin
            o_rv_rdata <= i_ram_rdata;  // same edge as the ack flip
        end
    end

    // fresh byte straight from the ram, held copy afterwards
    assign o_port_rdata = port_rd_pend ? port_byte : port_hold;

endmodule

// ==== logic/nes_mem_top.sv ====
`timescale 1ns/10ps
// shared word memory top level
// console byte port and softcore bridge in front of the arbiter and ram

module nes_mem_top (
    input  logic                           clk,
    input  logic                           resetn,
    // console side
    input  logic                           i_loading,
    input  logic                           i_loader_write,
    input  logic [nes_mem_pkg::CPU_AW-1:0] i_loader_addr,
    input  logic [7:0]                     i_loader_data,
    input  logic [nes_mem_pkg::CPU_AW-1:0] i_cpu_addr,
    input  logic                           i_cpu_read,
    input  logic                           i_cpu_write,
    input  logic [7:0]                     i_cpu_din,
    output logic [7:0]                     o_cpu_dout,
    output logic                           o_reset_nes,
    // softcore side
    input  logic                           i_rv_valid,
    input  logic [nes_mem_pkg::RV_AW-1:0]  i_rv_addr,
    input  logic [31:0]                    i_rv_wdata,
    input  logic [3:0]                     i_rv_wstrb,
    output logic                           o_rv_ready,
    output logic [31:0]                    o_rv_rdata
);

    logic                                port_req;
    logic                                port_we;
    logic [nes_mem_pkg::CPU_AW-1:0]      port_addr;
    logic [7:0]                          port_wdata;
    logic                                rv_req;
    logic                                rv_req_ack;
    logic [nes_mem_pkg::RAM_WORD_AW-1:0] rv_word_addr;
    logic                                rv_we;
    logic [1:0]                          rv_ds;
    nes_mem_pkg::mem_word_t              rv_wdata;
    nes_mem_pkg::mem_word_t              rv_rdata;
    logic [nes_mem_pkg::RAM_WORD_AW-1:0] ram_addr;
    logic                                ram_we;
    logic [1:0]                          ram_be;
    nes_mem_pkg::mem_word_t              ram_wdata;
    nes_mem_pkg::mem_word_t              ram_rdata;

    loader_port u_loader_port (
        .clk(clk), .resetn(resetn),
        .i_loading(i_loading), .i_loader_write(i_loader_write),
        .i_loader_addr(i_loader_addr), .i_loader_data(i_loader_data),
        .i_cpu_addr(i_cpu_addr), .i_cpu_read(i_cpu_read),
        .i_cpu_write(i_cpu_write), .i_cpu_din(i_cpu_din),
        .o_port_req(port_req), .o_port_we(port_we),
        .o_port_addr(port_addr), .o_port_wdata(port_wdata),
        .o_reset_nes(o_reset_nes)
    );

    rv_bridge u_rv_bridge (
        .clk(clk), .resetn(resetn),
        .i_rv_valid(i_rv_valid), .i_rv_addr(i_rv_addr),
        .i_rv_wdata(i_rv_wdata), .i_rv_wstrb(i_rv_wstrb),
        .o_rv_ready(o_rv_ready), .o_rv_rdata(o_rv_rdata),
        .o_rv_req(rv_req), .i_rv_req_ack(rv_req_ack),
        .o_rv_word_addr(rv_word_addr), .o_rv_we(rv_we), .o_rv_ds(rv_ds),
        .o_rv_wdata(rv_wdata), .i_rv_rdata(rv_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk(clk), .resetn(resetn),
        .i_port_req(port_req), .i_port_we(port_we),
        .i_port_addr(port_addr), .i_port_wdata(port_wdata),
        .o_port_rdata(o_cpu_dout),
        .i_rv_req(rv_req), .o_rv_req_ack(rv_req_ack),
        .i_rv_word_addr(rv_word_addr), .i_rv_we(rv_we), .i_rv_ds(rv_ds),
        .i_rv_wdata(rv_wdata), .o_rv_rdata(rv_rdata),
        .o_ram_addr(ram_addr), .o_ram_we(ram_we), .o_ram_be(ram_be),
        .o_ram_wdata(ram_wdata), .i_ram_rdata(ram_rdata)
    );

    word_ram u_word_ram (
        .clk(clk),
        .i_addr(ram_addr), .i_we(ram_we), .i_be(ram_be),
        .i_wdata(ram_wdata), .o_rdata(ram_rdata)
    );

endmodule

// ==== tb/nes_mem_props.sv ====
`timescale 1ns/10ps
// bound assertions for the shared memory top level
// softcore ready, console reset edges, ignored cpu writes, bridge state

module nes_mem_props (
    input logic       clk,
    input logic       resetn,
    input logic       i_loading,
    input logic       i_loader_write,
    input logic       i_cpu_write,
    input logic       i_rv_valid,
    input logic       i_rv_ready,
    input logic       i_reset_nes,
    input logic       i_port_req,
    input logic       i_port_we,
    input logic       i_rv_req,
    input logic       i_rv_req_ack,
    input logic [2:0] i_rv_state
);

    // ready only answers a held request
    a_ready_in_valid: assert property (@(posedge clk) disable iff (!resetn)
        i_rv_ready |-> i_rv_valid)
        else $error("softcore ready without valid");

    a_reset_on_rise: assert property (@(posedge clk) disable iff (!resetn)
        $rose(i_loading) |=> i_reset_nes)
        else $error("console reset not raised after loading rose");

    a_reset_on_fall: assert property (@(posedge clk) disable iff (!resetn)
        $fell(i_loading) |=> !i_reset_nes)
        else $error("console reset not released after loading fell");

    // a cpu write during a load never reaches the ram
    a_no_cpu_write: assert property (@(posedge clk) disable iff (!resetn)
        (i_loading && i_cpu_write && !i_loader_write) |=> !(i_port_req && i_port_we))
        else $error("cpu write passed through while loading");

    // an idle bridge has no word access outstanding at the arbiter
    a_idle_no_req: assert property (@(posedge clk) disable iff (!resetn)
        (i_rv_state == nes_mem_pkg::RV_IDLE_REQ0) |-> (i_rv_req == i_rv_req_ack))
        else $error("bridge idle with a word access still outstanding");

endmodule

bind nes_mem_top nes_mem_props u_props (
    .clk(clk), .resetn(resetn),
    .i_loading(i_loading), .i_loader_write(i_loader_write),
    .i_cpu_write(i_cpu_write), .i_rv_valid(i_rv_valid),
    .i_rv_ready(o_rv_ready), .i_reset_nes(o_reset_nes),
    .i_port_req(port_req), .i_port_we(port_we),
    .i_rv_req(rv_req), .i_rv_req_ack(rv_req_ack),
    .i_rv_state(u_rv_bridge.rv_state)
);

// ==== tb/tb_nes_mem.sv ====
`timescale 1ns/10ps
// testbench for the shared word memory
// rom load, console reset, cpu byte traffic, softcore transfers, contention
// byte array model of the 8 KiB ram

module tb_nes_mem;

    localparam int WIN_BASE = 'h1f80;  // window crosses the 8 KiB wrap
    localparam int WIN_SIZE = 200;     // bytes, all loaded by the rom load
    localparam int HALF     = WIN_SIZE / 2;
    localparam int N_LOAD   = 200;
    localparam int N_CPU    = 300;
    localparam int N_RV     = 200;
    localparam int N_CROSS  = 50;
    localparam int N_BUSY   = 500;
    localparam int CYCLE_LIMIT =
        (N_LOAD * 2 + 20 + N_CPU + N_RV + N_CROSS * 5 + N_BUSY + WIN_SIZE) * 12 + 200;

    logic                           clk;
    logic                           resetn;
    logic                           i_loading;
    logic                           i_loader_write;
    logic [nes_mem_pkg::CPU_AW-1:0] i_loader_addr;
    logic [7:0]                     i_loader_data;
    logic [nes_mem_pkg::CPU_AW-1:0] i_cpu_addr;
    logic                           i_cpu_read;
    logic                           i_cpu_write;
    logic [7:0]                     i_cpu_din;
    logic [7:0]                     o_cpu_dout;
    logic                           o_reset_nes;
    logic                           i_rv_valid;
    logic [nes_mem_pkg::RV_AW-1:0]  i_rv_addr;
    logic [31:0]                    i_rv_wdata;
    logic [3:0]                     i_rv_wstrb;
    logic                           o_rv_ready;
    logic [31:0]                    o_rv_rdata;

    logic [7:0] model [8192];  // expected ram contents, one entry per byte
    logic       busy_done;
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;

    nes_mem_top dut0 (
        .clk(clk), .resetn(resetn),
        .i_loading(i_loading), .i_loader_write(i_loader_write),
        .i_loader_addr(i_loader_addr), .i_loader_data(i_loader_data),
        .i_cpu_addr(i_cpu_addr), .i_cpu_read(i_cpu_read),
        .i_cpu_write(i_cpu_write), .i_cpu_din(i_cpu_din),
        .o_cpu_dout(o_cpu_dout), .o_reset_nes(o_reset_nes),
        .i_rv_valid(i_rv_valid), .i_rv_addr(i_rv_addr),
        .i_rv_wdata(i_rv_wdata), .i_rv_wstrb(i_rv_wstrb),
        .o_rv_ready(o_rv_ready), .o_rv_rdata(o_rv_rdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // address and random helpers
    ////////////////////////////////////////

    function automatic logic [12:0] win_addr(input int offset);
        int sum;
        sum = WIN_BASE + offset;
        return sum[12:0];  // byte address modulo 8 KiB
    endfunction

    function automatic int rand_below(input int n);
        return $urandom % n;
    endfunction

    // random upper bits, the ram only decodes the low 13
    function automatic logic [nes_mem_pkg::CPU_AW-1:0] cpu_addr_of(input logic [12:0] a);
        logic [31:0] r;
        r = $urandom;
        return {r[nes_mem_pkg::CPU_AW-1:13], a};
    endfunction

    function automatic logic [nes_mem_pkg::RV_AW-1:0] rv_addr_of(input logic [12:0] a);
        logic [31:0] r;
        r = $urandom;
        return {r[nes_mem_pkg::RV_AW-1:13], a};
    endfunction

    // reads, one half only, or any mix
    function automatic logic [3:0] rand_strb();
        logic [31:0] r;
        r = $urandom;
        case (r[1:0])
            2'd0:    return 4'b0000;
            2'd1:    return {2'b00, (r[3:2] == 2'b00) ? 2'b01 : r[3:2]};
            2'd2:    return {(r[5:4] == 2'b00) ? 2'b11 : r[5:4], 2'b00};
            default: return r[9:6];
        endcase
    endfunction

    ////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////

    task automatic loader_write(input logic [12:0] a, input logic [7:0] d);
        @(negedge clk);
        i_loader_addr  = cpu_addr_of(a);
        i_loader_data  = d;
        i_loader_write = 1'b1;
        model[a]       = d;
        @(negedge clk);
        i_loader_write = 1'b0;
        repeat (2) @(negedge clk);  // one pulse per 4 cycles
    endtask

    // one cpu strobe, read data checked 2 cycles later
    task automatic cpu_access(input logic wr, input logic [12:0] a, input logic [7:0] d);
        logic [7:0] exp;
        @(negedge clk);
        i_cpu_addr  = cpu_addr_of(a);
        i_cpu_din   = d;
        i_cpu_read  = ~wr;
        i_cpu_write = wr;
        exp         = model[a];
        if (wr && !i_loading) begin
            model[a] = d;  // ignored while loading
        end
        @(negedge clk);
        i_cpu_read  = 1'b0;
        i_cpu_write = 1'b0;
        @(negedge clk);
        if (!wr && !i_loading) begin
            checks++;
            if (o_cpu_dout !== exp) begin
                errors++;
                $display("MISMATCH at %0t: cpu read %h got %h expected %h",
                         $time, a, o_cpu_dout, exp);
            end
        end
        @(negedge clk);
    endtask

    // one softcore transfer, a is word aligned
    task automatic rv_transfer(input logic [12:0] a, input logic [31:0] wd,
                               input logic [3:0] ws);
        logic [31:0] exp;
        @(negedge clk);
        i_rv_addr  = rv_addr_of(a);
        i_rv_wdata = wd;
        i_rv_wstrb = ws;
        i_rv_valid = 1'b1;
        for (int k = 0; k < 4; k++) begin
            exp[8*k +: 8] = model[{a[12:2], 2'(k)}];  // little endian
        end
        do begin
            @(negedge clk);
        end while (!o_rv_ready);
        if (ws == 4'b0000) begin
            checks++;
            if (o_rv_rdata !== exp) begin
                errors++;
                $display("MISMATCH at %0t: softcore read %h got %h expected %h",
                         $time, a, o_rv_rdata, exp);
            end
        end else begin
            for (int k = 0; k < 4; k++) begin
                if (ws[k]) begin
                    model[{a[12:2], 2'(k)}] = wd[8*k +: 8];
                end
            end
        end
        @(negedge clk);  // valid held through the ready cycle
        i_rv_valid = 1'b0;
    endtask

    // loading edge, console reset follows one cycle later
    task automatic set_loading(input logic level);
        @(negedge clk);
        i_loading = level;
        @(negedge clk);
        checks++;
        if (o_reset_nes !== level) begin
            errors++;
            $display("MISMATCH at %0t: o_reset_nes is %b one cycle after loading went %b",
                     $time, o_reset_nes, level);
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] r;
        int          off;
        void'($urandom(32'h283e));
        resetn         = 1'b0;
        i_loading      = 1'b0;
        i_loader_write = 1'b0;
        i_loader_addr  = '0;
        i_loader_data  = 8'h00;
        i_cpu_addr     = '0;
        i_cpu_read     = 1'b0;
        i_cpu_write    = 1'b0;
        i_cpu_din      = 8'h00;
        i_rv_valid     = 1'b0;
        i_rv_addr      = '0;
        i_rv_wdata     = 32'h0;
        i_rv_wstrb     = 4'h0;
        busy_done      = 1'b0;
        repeat (2) @(negedge clk);
        checks++;
        if (o_reset_nes !== 1'b1 || o_rv_ready !== 1'b0 || dut0.ram_we !== 1'b0) begin
            errors++;
            $display("MISMATCH at %0t: reset state reset_nes %b rv_ready %b ram_we %b",
                     $time, o_reset_nes, o_rv_ready, dut0.ram_we);
        end
        resetn = 1'b1;

        // rom load, then read it all back
        set_loading(1'b1);
        for (int i = 0; i < N_LOAD; i++) begin
            r = $urandom;
            loader_write(win_addr(i), r[7:0]);
        end
        set_loading(1'b0);
        for (int i = 0; i < N_LOAD; i++) begin
            cpu_access(1'b0, win_addr(i), 8'h00);
        end

        // second load with cpu writes that must be ignored
        checks++;
        if (o_reset_nes !== 1'b0) begin
            errors++;
            $display("MISMATCH at %0t: o_reset_nes still high after the load", $time);
        end
        set_loading(1'b1);
        for (int i = 0; i < 20; i++) begin
            r = $urandom;
            cpu_access(1'b1, win_addr(rand_below(WIN_SIZE)), r[7:0]);
        end
        set_loading(1'b0);

        for (int i = 0; i < N_CPU; i++) begin
            r = $urandom;
            cpu_access(r[0], win_addr(rand_below(WIN_SIZE)), r[15:8]);
        end

        for (int i = 0; i < N_RV; i++) begin
            rv_transfer(win_addr(4 * rand_below(WIN_SIZE / 4)), $urandom, rand_strb());
        end

        // cross view, cpu bytes into softcore words and back
        for (int i = 0; i < N_CROSS; i++) begin
            off = 4 * rand_below(WIN_SIZE / 4);
            if (i % 2 == 0) begin
                for (int k = 0; k < 4; k++) begin
                    r = $urandom;
                    cpu_access(1'b1, win_addr(off + k), r[7:0]);
                end
                rv_transfer(win_addr(off), 32'h0, 4'b0000);
            end else begin
                rv_transfer(win_addr(off), $urandom, 4'b1111);
                for (int k = 0; k < 4; k++) begin
                    cpu_access(1'b0, win_addr(off + k), 8'h00);
                end
            end
        end

        // contention, cpu in the low half, softcore in the high half
        fork
            begin
                for (int i = 0; i < N_BUSY / 4; i++) begin
                    r = $urandom;
                    cpu_access(r[0], win_addr(rand_below(HALF)), r[15:8]);
                end
                busy_done = 1'b1;
            end
            begin
                while (!busy_done) begin
                    rv_transfer(win_addr(HALF + 4 * rand_below(HALF / 4)), $urandom,
                                rand_strb());
                end
            end
        join

        for (int i = 0; i < WIN_SIZE; i++) begin
            cpu_access(1'b0, win_addr(i), 8'h00);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== nes_mem_top.f ====
logic/nes_mem_pkg.sv
logic/word_ram.sv
logic/loader_port.sv
logic/rv_bridge.sv
logic/mem_arbiter.sv
logic/nes_mem_top.sv
tb/nes_mem_props.sv
tb/tb_nes_mem.sv

// ==== Makefile ====
# Verilator build and run of the shared word memory testbench

VERILATOR ?= verilator
TOP       ?= tb_nes_mem
FILELIST  ?= nes_mem_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi; \
	if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation stopped early"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
